// File: include/rob_cfg.svh
`ifndef ROB_CFG_SVH
`define ROB_CFG_SVH

// buffer depth as a power of two from 4 up
`define ROB_DEPTH 8
// log2 of ROB_DEPTH
`define TAG_W 3

// architectural register file
`define NREG 32
`define REG_W 5

`define XLEN 32
`define ALEN 32

`endif

// File: design/rob_pkg.sv
`include "rob_cfg.svh"

package rob_pkg;

    typedef logic [`TAG_W-1:0] tag_t;
    typedef logic [`REG_W-1:0] reg_idx_t;
    typedef logic [`XLEN-1:0]  word_t;
    typedef logic [`ALEN-1:0]  addr_t;

    // rd of zero means no register write
    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        logic     is_store;
        logic     is_branch;
        logic     pred_taken;
    } alloc_req_t;

    // taken is the resolved branch direction
    typedef struct packed {
        logic  valid;
        tag_t  tag;
        word_t data;
        logic  taken;
        addr_t target;
    } complete_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        word_t    data;
        tag_t     tag;
    } retire_t;

endpackage

// File: design/rename_table.sv
`timescale 1ns/10ps
`include "rob_cfg.svh"

module rename_table (
    input  logic                clk,
    input  logic                rst,
    input  rob_pkg::alloc_req_t alloc,
    input  rob_pkg::tag_t       alloc_tag,
    input  rob_pkg::retire_t    retire,
    input  logic                flush,
    input  rob_pkg::reg_idx_t   src_reg,
    output logic                src_pending,
    output rob_pkg::tag_t       src_tag
);
    import rob_pkg::*;

    logic [`NREG-1:0] busy;
    tag_t             writer [`NREG];

    logic alloc_set;
    logic release_hit;

    // register zero never gets a writer
    assign alloc_set = alloc.valid && (alloc.rd != '0);

    // only the newest writer frees the register
    assign release_hit = retire.valid && busy[retire.rd] && (writer[retire.rd] == retire.tag);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= '0;
        end else begin
            if (flush) begin
                busy <= '0;
            end else if (release_hit) begin
                busy[retire.rd] <= 1'b0;
            end
            // allocation after clear/release so it wins
            if (alloc_set) begin
                busy[alloc.rd] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_set) begin
            writer[alloc.rd] <= alloc_tag;
        end
    end

    // stale writers are hidden during the flush cycle
    assign src_pending = busy[src_reg] & ~flush;
    assign src_tag     = writer[src_reg];

endmodule

// File: design/reorder_buffer.sv
`timescale 1ns/10ps
`include "rob_cfg.svh"

module reorder_buffer (
    input  logic                clk,
    input  logic                rst,
    input  rob_pkg::alloc_req_t alloc,
    output rob_pkg::tag_t       alloc_tag,
    output logic                full,
    input  rob_pkg::complete_t  complete,
    input  rob_pkg::tag_t       lookup_tag,
    output logic                lookup_done,
    output rob_pkg::word_t      lookup_data,
    output rob_pkg::retire_t    retire,
    output logic                store_release,
    output rob_pkg::tag_t       store_tag,
    output logic                flush,
    output rob_pkg::addr_t      redirect_pc
);
    import rob_pkg::*;

    // per-entry state
    logic [`ROB_DEPTH-1:0] occupied;
    logic [`ROB_DEPTH-1:0] done;
    reg_idx_t              ent_rd     [`ROB_DEPTH];
    word_t                 ent_data   [`ROB_DEPTH];
    addr_t                 ent_target [`ROB_DEPTH];
    logic [`ROB_DEPTH-1:0] ent_store;
    logic [`ROB_DEPTH-1:0] ent_branch;
    logic [`ROB_DEPTH-1:0] ent_pred;
    logic [`ROB_DEPTH-1:0] ent_taken;

    tag_t          head;
    tag_t          tail;
    logic [`TAG_W:0] count;

    logic    comp_en;
    logic    head_fire;
    logic    mispredict;
    retire_t head_rec;

    assign alloc_tag = tail;
    assign full      = (count == `ROB_DEPTH);

    // results arriving in the flush cycle belong to squashed entries
    assign comp_en = complete.valid & ~flush;

    assign head_fire  = occupied[head] & done[head];
    assign mispredict = head_fire & ent_branch[head] & (ent_pred[head] != ent_taken[head]);

    // mispredicted branch with rd zero has no link write
    always_comb begin
        head_rec.valid = head_fire & ~ent_store[head] & (~mispredict | (ent_rd[head] != '0));
        head_rec.rd    = ent_rd[head];
        head_rec.data  = ent_data[head];
        head_rec.tag   = head;
    end

    assign lookup_done = occupied[lookup_tag] & done[lookup_tag];
    assign lookup_data = ent_data[lookup_tag];

    always_ff @(posedge clk) begin
        if (rst) begin
            occupied      <= '0;
            done          <= '0;
            head          <= '0;
            tail          <= '0;
            count         <= '0;
            retire        <= '0;
            store_release <= 1'b0;
            flush         <= 1'b0;
        end else begin
            retire        <= head_rec;
            store_release <= head_fire & ent_store[head];
            flush         <= mispredict;

            if (mispredict) begin
                // squash everything including the younger allocation
                occupied <= '0;
                done     <= '0;
                head     <= '0;
                tail     <= '0;
                count    <= '0;
            end else begin
                if (comp_en) begin
                    done[complete.tag] <= 1'b1;
                end
                if (head_fire) begin
                    occupied[head] <= 1'b0;
                    head           <= head + `TAG_W'(1);
                end
                if (alloc.valid) begin
                    occupied[tail] <= 1'b1;
                    done[tail]     <= 1'b0;
                    tail           <= tail + `TAG_W'(1);
                end
                count <= count + {`TAG_W'(0), alloc.valid} - {`TAG_W'(0), head_fire};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc.valid) begin
            ent_rd[tail]     <= alloc.rd;
            ent_store[tail]  <= alloc.is_store;
            ent_branch[tail] <= alloc.is_branch;
            ent_pred[tail]   <= alloc.pred_taken;
        end
        if (comp_en) begin
            ent_data[complete.tag]   <= complete.data;
            ent_taken[complete.tag]  <= complete.taken;
            ent_target[complete.tag] <= complete.target;
        end
        // qualified by store_release / flush
        if (head_fire) begin
            store_tag   <= head;
            redirect_pc <= ent_target[head];
        end
    end

endmodule

// File: design/arch_regfile.sv
`timescale 1ns/10ps
`include "rob_cfg.svh"

module arch_regfile (
    input  logic              clk,
    input  logic              rst,
    input  rob_pkg::retire_t  retire,
    input  rob_pkg::reg_idx_t rd_addr,
    output rob_pkg::word_t    rd_data
);

    logic [`XLEN-1:0] regs [`NREG];
    logic             wr_en;

    // x0 stays zero
    assign wr_en = retire.valid && (retire.rd != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `NREG; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[retire.rd] <= retire.data;
        end
    end

    assign rd_data = regs[rd_addr];

endmodule

// File: design/rob_core.sv
`timescale 1ns/10ps

module rob_core (
    input  logic                clk,
    input  logic                rst,
    input  rob_pkg::alloc_req_t alloc,
    output rob_pkg::tag_t       alloc_tag,
    input  rob_pkg::complete_t  complete,
    input  rob_pkg::reg_idx_t   src_reg,
    output logic                src_busy,
    output rob_pkg::tag_t       src_tag,
    output rob_pkg::word_t      src_data,
    output rob_pkg::retire_t    retire,
    output logic                store_release,
    output rob_pkg::tag_t       store_tag,
    output logic                flush,
    output rob_pkg::addr_t      redirect_pc,
    output logic                full
);
    import rob_pkg::*;

    logic  tbl_pending;
    tag_t  tbl_tag;
    logic  rob_done;
    word_t rob_data;
    word_t rf_data;
    logic  ret_hit;

    reorder_buffer rob0 (
        .clk          (clk),
        .rst          (rst),
        .alloc        (alloc),
        .alloc_tag    (alloc_tag),
        .full         (full),
        .complete     (complete),
        .lookup_tag   (tbl_tag),
        .lookup_done  (rob_done),
        .lookup_data  (rob_data),
        .retire       (retire),
        .store_release(store_release),
        .store_tag    (store_tag),
        .flush        (flush),
        .redirect_pc  (redirect_pc)
    );

    rename_table rt0 (
        .clk        (clk),
        .rst        (rst),
        .alloc      (alloc),
        .alloc_tag  (alloc_tag),
        .retire     (retire),
        .flush      (flush),
        .src_reg    (src_reg),
        .src_pending(tbl_pending),
        .src_tag    (tbl_tag)
    );

    arch_regfile rf0 (
        .clk    (clk),
        .rst    (rst),
        .retire (retire),
        .rd_addr(src_reg),
        .rd_data(rf_data)
    );

    // retire record is in flight to the register file this cycle
    assign ret_hit = retire.valid && (retire.rd == src_reg) &&
                     (!tbl_pending || (tbl_tag == retire.tag));

    always_comb begin
        src_busy = 1'b0;
        src_tag  = tbl_tag;
        src_data = rf_data;
        if (src_reg == '0) begin
            src_data = '0;
        end else if (ret_hit) begin
            src_data = retire.data;
        end else if (tbl_pending) begin
            if (rob_done) begin
                src_data = rob_data;
            end else begin
                src_busy = 1'b1;
            end
        end
    end

endmodule

// File: bench/rob_checker.sv
`timescale 1ns/10ps

module rob_checker (
    input logic                clk,
    input logic                rst,
    input rob_pkg::alloc_req_t alloc,
    input rob_pkg::retire_t    retire,
    input logic                store_release,
    input logic                flush,
    input logic                full
);

    int fail_count = 0;

    // producer has to hold while the buffer is full
    no_alloc_when_full: assert property (@(posedge clk) disable iff (rst)
        full |-> !alloc.valid)
        else begin
            $error("allocation presented while the buffer is full");
            fail_count++;
        end

    flush_one_cycle: assert property (@(posedge clk) disable iff (rst)
        flush |=> !flush)
        else begin
            $error("flush stayed high for more than one cycle");
            fail_count++;
        end

    store_or_retire: assert property (@(posedge clk) disable iff (rst)
        !(store_release && retire.valid))
        else begin
            $error("store release and register retire raised together");
            fail_count++;
        end

    // a store never redirects
    no_store_flush: assert property (@(posedge clk) disable iff (rst)
        !(store_release && flush))
        else begin
            $error("flush raised while a store was released");
            fail_count++;
        end

endmodule

bind rob_core rob_checker chk0 (
    .clk          (clk),
    .rst          (rst),
    .alloc        (alloc),
    .retire       (retire),
    .store_release(store_release),
    .flush        (flush),
    .full         (full)
);

// File: bench/rob_tb.sv
`timescale 1ns/10ps
`include "rob_cfg.svh"

module rob_tb;
    import rob_pkg::*;

    localparam int N_CYCLES = 4000;

    // program-order model entry
    typedef struct packed {
        reg_idx_t rd;
        logic     st;
        logic     br;
        logic     pred;
        logic     done;
        logic     taken;
        word_t    data;
        addr_t    target;
    } ent_t;

    logic       clk = 1'b0;
    logic       rst;
    alloc_req_t alloc;
    tag_t       alloc_tag;
    complete_t  complete;
    reg_idx_t   src_reg;
    logic       src_busy;
    tag_t       src_tag;
    word_t      src_data;
    retire_t    retire;
    logic       store_release;
    tag_t       store_tag;
    logic       flush;
    addr_t      redirect_pc;
    logic       full;

    ent_t    q [$];
    word_t   arch [`NREG];
    tag_t    head_tag;
    retire_t exp_ret;
    logic    exp_st;
    logic    exp_fl;
    tag_t    exp_st_tag;
    addr_t   exp_pc;
    int      checks;
    int      errors;

    rob_core dut0 (.*);

    always #20 clk = ~clk;

    initial begin
        #((N_CYCLES + 20) * 40);
        $display("watchdog expired before the test finished");
        $display("*** TEST FAILED ***");
        $finish;
    end

    task automatic expect_eq(input string what, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_outputs();
        expect_eq("retire.valid", 64'(retire.valid), 64'(exp_ret.valid));
        if (exp_ret.valid)
            expect_eq("retire record", 64'(retire), 64'(exp_ret));
        expect_eq("store_release", 64'(store_release), 64'(exp_st));
        if (exp_st)
            expect_eq("store_tag", 64'(store_tag), 64'(exp_st_tag));
        expect_eq("flush", 64'(flush), 64'(exp_fl));
        if (exp_fl)
            expect_eq("redirect_pc", 64'(redirect_pc), 64'(exp_pc));
        expect_eq("full", 64'(full), 64'(q.size() == `ROB_DEPTH));
        expect_eq("alloc_tag", 64'(alloc_tag), 64'(tag_t'(head_tag + q.size())));
    endtask

    // newest in-flight writer decides the answer
    task automatic check_lookup(input reg_idx_t r);
        int   j;
        logic exp_busy;
        j = -1;
        for (int i = 0; i < q.size(); i++)
            if (r != '0 && q[i].rd == r)
                j = i;
        exp_busy = (j >= 0) && !q[j].done;
        expect_eq($sformatf("x%0d busy", r), 64'(src_busy), 64'(exp_busy));
        if (exp_busy)
            expect_eq($sformatf("x%0d tag", r), 64'(src_tag), 64'(tag_t'(head_tag + j)));
        else
            expect_eq($sformatf("x%0d data", r), 64'(src_data),
                      64'((j < 0) ? arch[r] : q[j].data));
    endtask

    // what the next clock edge does to the model
    task automatic advance_model(input alloc_req_t a, input complete_t c, input int ci);
        ent_t h;
        logic head_ready;
        logic mis;
        head_ready = (q.size() > 0) && q[0].done;
        exp_ret = '0;
        exp_st = 1'b0;
        exp_fl = 1'b0;
        if (c.valid) begin
            h = q[ci];
            h.done = 1'b1;
            h.data = c.data;
            h.taken = c.taken;
            h.target = c.target;
            q[ci] = h;
        end
        if (head_ready) begin
            h = q.pop_front();
            mis = h.br && (h.pred != h.taken);
            if (h.st) begin
                exp_st = 1'b1;
                exp_st_tag = head_tag;
            end else if (!mis || h.rd != '0) begin
                exp_ret = '{1'b1, h.rd, h.data, head_tag};
                if (h.rd != '0)
                    arch[h.rd] = h.data;
            end
            head_tag++;
            if (mis) begin
                // younger entries and this edge's allocation are gone
                exp_fl = 1'b1;
                exp_pc = h.target;
                q.delete();
                head_tag = '0;
                return;
            end
        end
        if (a.valid) begin
            h = '{a.rd, a.is_store, a.is_branch, a.pred_taken, 1'b0, 1'b0, '0, '0};
            q.push_back(h);
        end
    endtask

    initial begin
        alloc_req_t a;
        complete_t  c;
        int         open [$];
        int         ci;
        int         kind;
        logic       sweep;
        void'($urandom(32'h72a1_c9e2));
        rst = 1'b1;
        alloc = '0;
        complete = '0;
        src_reg = '0;
        for (int i = 0; i < `NREG; i++)
            arch[i] = '0;
        head_tag = '0;
        exp_ret = '0;
        exp_st = 1'b0;
        exp_fl = 1'b0;
        checks = 0;
        errors = 0;
        ci = 0;
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;
        compare_outputs();
        sweep = 1'b1;
        for (int cyc = 0; cyc < N_CYCLES; cyc++) begin
            a = '0;
            if (q.size() < `ROB_DEPTH && $urandom_range(99) < 70) begin
                kind = $urandom_range(9);
                a.valid = 1'b1;
                a.is_store = (kind == 6 || kind == 7);
                a.is_branch = (kind >= 8);
                a.rd = a.is_store ? '0 : reg_idx_t'($urandom_range(11));
                a.pred_taken = 1'($urandom_range(1));
            end
            c = '0;
            open.delete();
            for (int i = 0; i < q.size(); i++)
                if (!q[i].done)
                    open.push_back(i);
            if (open.size() > 0 && $urandom_range(99) < 55) begin
                ci = open[$urandom_range(open.size() - 1)];
                c.valid = 1'b1;
                c.tag = tag_t'(head_tag + ci);
                c.data = $urandom();
                // about one branch in ten resolves against its prediction
                c.taken = q[ci].pred ^ ($urandom_range(9) == 0);
                c.target = $urandom() & 32'hffff_fffc;
            end
            alloc = a;
            complete = c;
            if (sweep) begin
                for (int r = 0; r < `NREG; r++) begin
                    src_reg = reg_idx_t'(r);
                    #0.5;
                    check_lookup(reg_idx_t'(r));
                end
            end else begin
                src_reg = reg_idx_t'($urandom_range(31));
                #1;
                check_lookup(src_reg);
            end
            advance_model(a, c, ci);
            sweep = exp_fl;
            @(posedge clk);
            #2;
            compare_outputs();
        end
        $display("checks run: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, dut0.chk0.fail_count);
        if (errors == 0 && dut0.chk0.fail_count == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// File: all.f
+incdir+include
design/rob_pkg.sv
design/rename_table.sv
design/reorder_buffer.sv
design/arch_regfile.sv
design/rob_core.sv
bench/rob_checker.sv
bench/rob_tb.sv

// File: Bender.yml
package:
  name: rob_core

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/rob_pkg.sv
      - design/rename_table.sv
      - design/reorder_buffer.sv
      - design/arch_regfile.sv
      - design/rob_core.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/rob_checker.sv
      - bench/rob_tb.sv
